// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vproc_div_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/vproc_div_block.sv ====
// single 32-bit lane, no reset and no valid; latency is BUF_OPS + BUF_DIV + BUF_RES cycles
module vproc_div_block
    import vproc_pkg::*;
#(
    parameter bit BUF_OPS = 1'b0, // register operands and op
    parameter bit BUF_DIV = 1'b0, // register raw division result
    parameter bit BUF_RES = 1'b0  // register res_o
) (
    input  logic            clk_i,
    input  div_op_e         op_i,
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    output logic [XLEN-1:0] res_o
);

    localparam logic [XLEN-1:0] INT_MIN = {1'b1, {(XLEN-1){1'b0}}};

    div_op_e         op_q;
    logic [XLEN-1:0] op1_q;
    logic [XLEN-1:0] op2_q;
    logic [XLEN-1:0] div_d;
    logic [XLEN-1:0] div_q;
    logic [XLEN-1:0] res_d;
    logic [XLEN-1:0] res_q;
    logic            div_zero;
    logic            sgn_ovf;

    generate
        if (BUF_OPS) begin : g_buf_ops
            always_ff @(posedge clk_i) begin
                op_q  <= op_i;
                op1_q <= op1_i;
                op2_q <= op2_i;
            end
        end else begin : g_pass_ops
            assign op_q  = op_i;
            assign op1_q = op1_i;
            assign op2_q = op2_i;
        end
    endgenerate

    assign div_zero = (op2_q == '0);
    assign sgn_ovf  = (op1_q == INT_MIN) && (op2_q == '1); // only meaningful for signed ops

    always_comb begin
        case (op_q)
            DIV_OP_DIVU: begin
                if (div_zero) begin
                    div_d = '1;
                end else begin
                    div_d = op1_q / op2_q;
                end
            end
            DIV_OP_DIV: begin
                if (div_zero) begin
                    div_d = '1;
                end else if (sgn_ovf) begin
                    div_d = op1_q;
                end else begin
                    div_d = $signed(op1_q) / $signed(op2_q);
                end
            end
            DIV_OP_REMU: begin
                if (div_zero) begin
                    div_d = op1_q;
                end else begin
                    div_d = op1_q % op2_q;
                end
            end
            DIV_OP_REM: begin
                if (div_zero) begin
                    div_d = op1_q;
                end else if (sgn_ovf) begin
                    div_d = '0;
                end else begin
                    div_d = $signed(op1_q) % $signed(op2_q); // sign follows dividend
                end
            end
            default: div_d = '0;
        endcase
    end

    generate
        if (BUF_DIV) begin : g_buf_div
            always_ff @(posedge clk_i) begin
                div_q <= div_d;
            end
        end else begin : g_pass_div
            assign div_q = div_d;
        end

        if (BUF_RES) begin : g_buf_res
            always_ff @(posedge clk_i) begin
                res_q <= res_d;
            end
        end else begin : g_pass_res
            assign res_q = res_d;
        end
    endgenerate

    assign res_d = div_q;
    assign res_o = res_q;

endmodule

// ==== hw/vproc_div_decoder.sv ====
// one cycle decode, only the four divide funct6 codes are legal; no stall input, accepts every cycle
module vproc_div_decoder
    import vproc_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  div_req_t req_i,
    output div_cmd_t cmd_o
);

    div_op_e          op_d;
    logic             illegal_d;
    logic [VEC_W-1:0] op2_d;
    div_cmd_t         cmd_q;

    always_comb begin
        illegal_d = 1'b0;
        unique case (req_i.funct6)
            FUNCT6_DIVU: op_d = DIV_OP_DIVU;
            FUNCT6_DIV:  op_d = DIV_OP_DIV;
            FUNCT6_REMU: op_d = DIV_OP_REMU;
            FUNCT6_REM:  op_d = DIV_OP_REM;
            default: begin
                op_d      = DIV_OP_DIVU; // lanes run, result gets dropped
                illegal_d = 1'b1;
            end
        endcase
    end

    // broadcast rs1 for the .vx form
    assign op2_d = req_i.vx ? {DIV_LANES{req_i.rs1}} : req_i.vs1;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cmd_q.valid <= 1'b0;
        end else begin
            cmd_q.valid <= req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        cmd_q.illegal <= illegal_d;
        cmd_q.op      <= op_d;
        cmd_q.tag     <= req_i.tag;
        cmd_q.mask    <= req_i.mask;
        cmd_q.op1     <= req_i.vs2;
        cmd_q.op2     <= op2_d;
        cmd_q.vd_old  <= req_i.vd_old;
    end

    assign cmd_o = cmd_q;

endmodule

// ==== hw/vproc_div_top.sv ====
// request to result is 1 + DIV_LATENCY cycles (3 as configured); one request per cycle, no stall
module vproc_div_top
    import vproc_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  div_req_t req_i,
    output div_res_t res_o
);

    div_cmd_t cmd; // registered decode

    vproc_div_decoder u_vproc_div_decoder (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .cmd_o   (cmd)
    );

    vproc_div_unit u_vproc_div_unit (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cmd_i   (cmd),
        .res_o   (res_o)
    );

endmodule

// ==== hw/vproc_div_unit.sv ====
// four lanes in lockstep, metadata delayed by DIV_LATENCY; no back-pressure, results in order
module vproc_div_unit
    import vproc_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  div_cmd_t cmd_i,
    output div_res_t res_o
);

    typedef struct packed {
        logic                 valid;
        logic                 illegal;
        logic [TAG_W-1:0]     tag;
        logic [DIV_LANES-1:0] mask;
        logic [VEC_W-1:0]     vd_old;
    } meta_t;

    logic [VEC_W-1:0] lane_res;
    meta_t            meta_in;
    meta_t            meta_out;

    for (genvar k = 0; k < DIV_LANES; k++) begin : g_lane
        vproc_div_block #(
            .BUF_OPS (DIV_BUF_OPS),
            .BUF_DIV (DIV_BUF_DIV),
            .BUF_RES (DIV_BUF_RES)
        ) u_div_block (
            .clk_i (clk_i),
            .op_i  (cmd_i.op),
            .op1_i (cmd_i.op1[k*XLEN +: XLEN]),
            .op2_i (cmd_i.op2[k*XLEN +: XLEN]),
            .res_o (lane_res[k*XLEN +: XLEN])
        );
    end

    assign meta_in = '{
        valid:   cmd_i.valid,
        illegal: cmd_i.illegal,
        tag:     cmd_i.tag,
        mask:    cmd_i.mask,
        vd_old:  cmd_i.vd_old
    };

    generate
        if (DIV_LATENCY == 0) begin : g_no_delay
            assign meta_out = meta_in;
        end else begin : g_delay
            meta_t meta_q [DIV_LATENCY];

            always_ff @(posedge clk_i) begin
                meta_q[0] <= meta_in;
                for (int i = 1; i < DIV_LATENCY; i++) begin
                    meta_q[i] <= meta_q[i-1];
                end
                if (!rst_n_i) begin
                    for (int i = 0; i < DIV_LATENCY; i++) begin
                        meta_q[i].valid <= 1'b0; // only valid is cleared
                    end
                end
            end

            assign meta_out = meta_q[DIV_LATENCY-1];
        end
    endgenerate

    // masked-off or illegal elements keep the old destination
    always_comb begin
        res_o.valid   = meta_out.valid;
        res_o.illegal = meta_out.illegal;
        res_o.tag     = meta_out.tag;
        for (int k = 0; k < DIV_LANES; k++) begin
            if (meta_out.mask[k] && !meta_out.illegal) begin
                res_o.data[k*XLEN +: XLEN] = lane_res[k*XLEN +: XLEN];
            end else begin
                res_o.data[k*XLEN +: XLEN] = meta_out.vd_old[k*XLEN +: XLEN];
            end
        end
    end

endmodule

// ==== hw/vproc_pkg.sv ====
// fixed 32-bit elements in four lanes; no vector length, no register file, buffer setup fixed here
package vproc_pkg;

    localparam int unsigned XLEN      = 32;
    localparam int unsigned DIV_LANES = 4;
    localparam int unsigned VEC_W     = XLEN * DIV_LANES;
    localparam int unsigned TAG_W     = 4;

    // lane pipeline setup used by the unit
    localparam bit DIV_BUF_OPS = 1'b1;
    localparam bit DIV_BUF_DIV = 1'b0;
    localparam bit DIV_BUF_RES = 1'b1;

    localparam int unsigned DIV_LATENCY = int'(DIV_BUF_OPS) + int'(DIV_BUF_DIV)
                                        + int'(DIV_BUF_RES);

    // rvv opivv/opivx funct6 encodings
    localparam logic [5:0] FUNCT6_DIVU = 6'b100000;
    localparam logic [5:0] FUNCT6_DIV  = 6'b100001;
    localparam logic [5:0] FUNCT6_REMU = 6'b100010;
    localparam logic [5:0] FUNCT6_REM  = 6'b100011;

    typedef enum logic [1:0] {
        DIV_OP_DIVU = 2'd0,
        DIV_OP_DIV  = 2'd1,
        DIV_OP_REMU = 2'd2,
        DIV_OP_REM  = 2'd3
    } div_op_e;

    typedef struct packed {
        logic                 valid;
        logic [5:0]           funct6;
        logic                 vx;       // scalar divisor form
        logic [TAG_W-1:0]     tag;
        logic [DIV_LANES-1:0] mask;
        logic [VEC_W-1:0]     vs2;      // dividend
        logic [VEC_W-1:0]     vs1;      // divisor vector
        logic [XLEN-1:0]      rs1;      // divisor scalar
        logic [VEC_W-1:0]     vd_old;
    } div_req_t;

    typedef struct packed {
        logic                 valid;
        logic                 illegal;
        div_op_e              op;
        logic [TAG_W-1:0]     tag;
        logic [DIV_LANES-1:0] mask;
        logic [VEC_W-1:0]     op1;
        logic [VEC_W-1:0]     op2;      // scalar already broadcast
        logic [VEC_W-1:0]     vd_old;
    } div_cmd_t;

    typedef struct packed {
        logic             valid;
        logic             illegal;
        logic [TAG_W-1:0] tag;
        logic [VEC_W-1:0] data;
    } div_res_t;

endpackage

// ==== sim.f ====
hw/vproc_pkg.sv
hw/vproc_div_decoder.sv
hw/vproc_div_block.sv
hw/vproc_div_unit.sv
hw/vproc_div_top.sv
tb/vproc_div_checker.sv
tb/vproc_div_tb.sv

// ==== tb/vproc_div_checker.sv ====
// bound into vproc_div_top; assumes the fixed request to result latency of 1 + DIV_LATENCY cycles
module vproc_div_checker
    import vproc_pkg::*;
(
    input logic     clk_i,
    input logic     rst_n_i,
    input div_req_t req_i,
    input div_res_t res_o
);

    localparam int unsigned LAT = 1 + DIV_LATENCY;

    int fail_cnt = 0;

    // delay line cleared one edge into reset
    assert property (@(posedge clk_i) !rst_n_i |=> !res_o.valid) else begin
        $error("result strobe high after a reset cycle");
        fail_cnt++;
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     req_i.valid |-> ##LAT res_o.valid) else begin
        $error("request without a result strobe at the expected latency");
        fail_cnt++;
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     res_o.valid |-> $past(req_i.valid, LAT)) else begin
        $error("result strobe without a matching request");
        fail_cnt++;
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     res_o.valid |-> !$isunknown(res_o.data)) else begin
        $error("unknown bits in result data");
        fail_cnt++;
    end

endmodule

bind vproc_div_top vproc_div_checker u_vproc_div_checker (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req_i),
    .res_o   (res_o)
);

// ==== tb/vproc_div_tb.sv ====
// 400 random requests plus directed corner cases; expects in-order results and the 3-cycle latency
module vproc_div_tb
    import vproc_pkg::*;
();

    localparam int N_RANDOM = 400;
    localparam int MAX_GAP  = 3;
    // worst case 8 reset + ~30 directed + 400 * (1 + MAX_GAP) random cycles, about 1700
    localparam int TIMEOUT_CYCLES = 3000;
    localparam logic [XLEN-1:0] INT_MIN = 32'h8000_0000;
    localparam logic [5:0] OPS [4] = '{FUNCT6_DIVU, FUNCT6_DIV, FUNCT6_REMU, FUNCT6_REM};

    logic             clk_i = 1'b0;
    logic             rst_n_i;
    div_req_t         req_i;
    div_res_t         res_o;
    div_res_t         exp_q [$];
    logic [TAG_W-1:0] next_tag = '0;
    int               seed = 32'hf5c5;
    int               n_mismatch = 0;
    int               n_other = 0;
    int               cycle_cnt = 0;

    vproc_div_top u_vproc_div_top (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .res_o   (res_o)
    );

    always #20 clk_i = ~clk_i;

    // one element by the rvv rules, signed cases through magnitudes in 64 bits
    function automatic logic [XLEN-1:0] elem_ref(input logic [5:0] f6,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
        logic   sgn;
        longint x;
        longint y;
        longint q;
        longint r;
        sgn = (f6 == FUNCT6_DIV) || (f6 == FUNCT6_REM);
        x = sgn ? longint'($signed(a)) : longint'({32'b0, a});
        y = sgn ? longint'($signed(b)) : longint'({32'b0, b});
        if (y == 0) begin
            q = '1;
            r = x;
        end else if (sgn && a == INT_MIN && b == '1) begin
            q = x;
            r = '0;
        end else begin
            q = (x < 0 ? -x : x) / (y < 0 ? -y : y);
            r = (x < 0 ? -x : x) % (y < 0 ? -y : y);
            if ((x < 0) != (y < 0)) begin
                q = -q;
            end
            if (x < 0) begin
                r = -r; // remainder takes the dividend's sign
            end
        end
        if (f6 == FUNCT6_DIVU || f6 == FUNCT6_DIV) begin
            return q[XLEN-1:0];
        end
        return r[XLEN-1:0];
    endfunction

    function automatic div_res_t res_ref(input div_req_t r);
        div_res_t        e;
        logic            legal;
        logic [XLEN-1:0] divisor;
        legal     = r.funct6 inside {FUNCT6_DIVU, FUNCT6_DIV, FUNCT6_REMU, FUNCT6_REM};
        e.valid   = 1'b1;
        e.illegal = !legal;
        e.tag     = r.tag;
        for (int k = 0; k < DIV_LANES; k++) begin
            divisor = r.vx ? r.rs1 : r.vs1[k*XLEN +: XLEN];
            if (legal && r.mask[k]) begin
                e.data[k*XLEN +: XLEN] = elem_ref(r.funct6, r.vs2[k*XLEN +: XLEN], divisor);
            end else begin
                e.data[k*XLEN +: XLEN] = r.vd_old[k*XLEN +: XLEN];
            end
        end
        return e;
    endfunction

    // biased towards zero, INT_MIN, minus one and small values
    function automatic logic [XLEN-1:0] rand_elem();
        int kind;
        kind = $random(seed) & 7;
        case (kind)
            0: return '0;
            1: return INT_MIN;
            2: return '1;
            3: return 32'($random(seed) % 100);
            default: return $random(seed);
        endcase
    endfunction

    function automatic div_req_t make_req(input logic [5:0] f6, input logic vx,
                                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        div_req_t r;
        r.valid  = 1'b1;
        r.funct6 = f6;
        r.vx     = vx;
        r.tag    = '0;
        r.mask   = 4'hf;
        r.vs2    = {DIV_LANES{a}};
        r.vs1    = vx ? {DIV_LANES{32'h5a5a_0003}} : {DIV_LANES{b}}; // junk vs1 in vx form
        r.rs1    = vx ? b : 32'h0bad_0001;
        r.vd_old = {32'hd003, 32'hd002, 32'hd001, 32'hd000};
        return r;
    endfunction

    task automatic issue(input div_req_t r);
        @(negedge clk_i);
        r.tag = next_tag;
        next_tag++;
        req_i = r;
        exp_q.push_back(res_ref(r));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk_i);
            req_i.valid = 1'b0;
        end
    endtask

    task automatic send_random();
        div_req_t r;
        r.valid  = 1'b1;
        r.funct6 = (($random(seed) & 15) == 0) ? 6'($random(seed))
                                               : {4'b1000, 2'($random(seed))};
        r.vx     = 1'($random(seed));
        r.tag    = '0;
        r.mask   = (($random(seed) & 3) == 0) ? 4'($random(seed)) : 4'hf;
        r.vs2    = {rand_elem(), rand_elem(), rand_elem(), rand_elem()};
        r.vs1    = {rand_elem(), rand_elem(), rand_elem(), rand_elem()};
        r.rs1    = rand_elem();
        r.vd_old = {$random(seed), $random(seed), $random(seed), $random(seed)};
        issue(r);
    endtask

    task automatic close_run();
        int n_chk;
        n_chk = u_vproc_div_top.u_vproc_div_checker.fail_cnt;
        $display("errors: %0d mismatch, %0d other, %0d assertion", n_mismatch, n_other, n_chk);
        if (n_mismatch + n_other + n_chk == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    always @(negedge clk_i) begin
        div_res_t e;
        if (rst_n_i && res_o.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("error: result strobe at %0t with no request outstanding", $time);
                n_other++;
            end else begin
                e = exp_q.pop_front();
                assert (res_o.tag === e.tag) else begin
                    $display("MISMATCH %0t res_o.tag exp %h got %h", $time, e.tag, res_o.tag);
                    n_mismatch++;
                end
                assert (res_o.illegal === e.illegal) else begin
                    $display("MISMATCH %0t res_o.illegal exp %b got %b", $time, e.illegal,
                             res_o.illegal);
                    n_mismatch++;
                end
                assert (res_o.data === e.data) else begin
                    $display("MISMATCH %0t res_o.data exp %h got %h", $time, e.data, res_o.data);
                    n_mismatch++;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            n_other++;
            close_run();
        end
    end

    initial begin
        div_req_t r;
        int       drain;
        req_i   = '0;
        rst_n_i = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        // corner cases, back to back
        for (int i = 0; i < 4; i++) begin
            issue(make_req(OPS[i], 1'b0, 32'd1234567, '0));
            issue(make_req(OPS[i], 1'b1, 32'hffff_fff9, '0));
            issue(make_req(OPS[i], 1'b0, INT_MIN, '1));
            issue(make_req(OPS[i], 1'b1, 32'hffff_ff9c, 32'd7)); // -100 by 7
            issue(make_req(OPS[i], 1'b0, 32'd100, 32'hffff_fff9));
        end
        r = make_req(FUNCT6_DIV, 1'b0, 32'd77, 32'd5);
        r.mask = 4'b0101;
        issue(r);
        r.mask = 4'b0000;
        issue(r);
        issue(make_req(6'b000000, 1'b0, 32'd9, 32'd3));
        issue(make_req(6'b100100, 1'b1, 32'd9, 32'd3));
        idle(2);
        for (int n = 0; n < N_RANDOM; n++) begin
            send_random();
            idle({$random(seed)} % (MAX_GAP + 1));
        end
        idle(1);
        drain = 0;
        while (exp_q.size() != 0 && drain < 2 * (1 + DIV_LATENCY)) begin
            @(negedge clk_i);
            drain++;
        end
        repeat (1 + DIV_LATENCY) @(negedge clk_i); // pipeline empty, stray strobes show up here
        if (exp_q.size() != 0) begin
            $display("error: %0d expected results never came out", exp_q.size());
            n_other++;
        end
        close_run();
    end

endmodule
